// File: Bender.yml
package:
  name: video_window

sources:
  - vid_window_pkg.sv
  - host_word_rx.sv
  - video_cmd_decoder.sv
  - umuldiv.sv
  - window_calc.sv
  - video_window_top.sv
  - target: test
    files:
      - tb_video_window.sv

// File: host_word_rx.sv
/*
 * Host word receiver
 * Brings the strobe/acknowledge host link into clk_sys, emits one word
 * per strobe while a frame is open and marks the command word
 */
module host_word_rx (
	input  logic                                i_clk_sys,
	input  logic                                i_resetd,
	input  logic [vid_window_pkg::WORD_W-1:0]   i_host_data,
	input  logic                                i_host_frame,
	input  logic                                i_host_strobe,
	output vid_window_pkg::host_word_t          o_word,
	output logic                                o_frame_sync,
	output logic                                o_host_ack
);
	import vid_window_pkg::*;

	logic [1:0]        frame_sr;
	logic [4:0]        strb_sr;
	logic [WORD_W-1:0] data_s1;
	logic [WORD_W-1:0] data_s2;
	logic [WORD_W-1:0] word_data;
	logic              word_valid;
	logic              word_first;
	logic              cmd_seen;
	logic              strb_rise;

	// Stages 0..1 synchronise, 2..4 delay the strobe
	assign strb_rise    = strb_sr[2] & ~strb_sr[3];
	assign o_frame_sync = frame_sr[1];
	assign o_host_ack   = strb_sr[4];

	assign o_word = '{valid: word_valid, first: word_first, data: word_data};

	// Data is stable while strobe is high
	always_ff @(posedge i_clk_sys) begin
		data_s1 <= i_host_data;
		data_s2 <= data_s1;
		if (strb_rise) begin
			word_data <= data_s2;
		end
	end

	always_ff @(posedge i_clk_sys) begin
		if (i_resetd) begin
			frame_sr   <= '0;
			strb_sr    <= '0;
			cmd_seen   <= 1'b0;
			word_valid <= 1'b0;
			word_first <= 1'b0;
		end else begin
			frame_sr   <= {frame_sr[0], i_host_frame};
			strb_sr    <= {strb_sr[3:0], i_host_strobe};
			word_valid <= strb_rise & frame_sr[1];
			if (strb_rise) begin
				word_first <= ~cmd_seen;
			end
			// Closed frame rearms the command marker
			if (!frame_sr[1]) begin
				cmd_seen <= 1'b0;
			end else if (strb_rise) begin
				cmd_seen <= 1'b1;
			end
		end
	end

endmodule

// File: tb_video_window.sv
/*
 * Video window testbench
 * Replays the command trace over the host link, keeps a reference model
 * of the configuration registers and checks every published window
 */
module tb_video_window;
	import vid_window_pkg::*;

	localparam int WAIT_LIMIT = 500;

	logic              clk_sys;
	logic              resetd;
	logic [WORD_W-1:0] host_data;
	logic              host_frame;
	logic              host_strobe;
	logic              host_ack;
	window_t           window;

	video_cfg_t        model_cfg;
	logic [WORD_W-1:0] frame_words[$];
	logic              saw_invalid;
	int unsigned       seed_val;
	int                check_count;

	video_window_top dut_i (
		.i_clk_sys     (clk_sys),
		.i_resetd      (resetd),
		.i_host_data   (host_data),
		.i_host_frame  (host_frame),
		.i_host_strobe (host_strobe),
		.o_host_ack    (host_ack),
		.o_window      (window)
	);

	always #10 clk_sys = ~clk_sys;

	task automatic check_value(input string what, input int actual, input int expected);
		check_count++;
		if (actual != expected) begin
			$display("FAIL %0t: %s is %0d, expected %0d", $time, what, actual, expected);
			$display("Done: errors found");
			$fatal(1, "Stopped at the first mismatch");
		end
	endtask

	task automatic stop_run(input string reason);
		$display("%0t: %s", $time, reason);
		$display("Done: errors found");
		$fatal(1, "Simulation stopped");
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Host link driver
	////////////////////////////////////////////////////////////////////////////

	// Also notes any cycle with the window invalid
	task automatic wait_ack(input logic level);
		int cycles;
		cycles = 0;
		while (host_ack !== level) begin
			@(negedge clk_sys);
			if (!window.valid) begin
				saw_invalid = 1'b1;
			end
			cycles++;
			if (cycles > WAIT_LIMIT) begin
				stop_run($sformatf("No acknowledge %s from the DUT", level ? "rise" : "fall"));
			end
		end
	endtask

	task automatic send_word(input logic [WORD_W-1:0] data, input logic drop_frame);
		host_data   = data;
		host_strobe = 1'b1;
		if (drop_frame) begin
			host_frame = 1'b0;
		end
		wait_ack(1'b1);
		host_strobe = 1'b0;
		wait_ack(1'b0);
		repeat ($urandom_range(3)) @(negedge clk_sys);
	endtask

	// Aborted frames lose the frame level as their last word goes out
	task automatic send_frame(input logic [7:0] cmd, input logic aborted);
		int last;
		last = frame_words.size() - 1;
		@(negedge clk_sys);
		saw_invalid = 1'b0;
		host_frame  = 1'b1;
		@(negedge clk_sys);
		send_word({8'h00, cmd}, aborted && last < 0);
		for (int i = 0; i <= last; i++) begin
			send_word(frame_words[i], aborted && i == last);
		end
		host_frame = 1'b0;
		repeat (4) @(negedge clk_sys);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Reference model
	////////////////////////////////////////////////////////////////////////////

	task automatic apply_frame(input logic [7:0] cmd, input int count);
		logic [WORD_W-1:0] w;
		for (int i = 0; i < count; i++) begin
			w = frame_words[i];
			case (cmd)
				CMD_TIMING: begin
					case (i)
						0: model_cfg.width  = w[DIM_W-1:0];
						1: model_cfg.hfp    = w[DIM_W-1:0];
						2: model_cfg.hs     = w[DIM_W-1:0];
						3: model_cfg.hbp    = w[DIM_W-1:0];
						4: model_cfg.height = w[DIM_W-1:0];
						5: model_cfg.vfp    = w[DIM_W-1:0];
						6: model_cfg.vs     = w[DIM_W-1:0];
						7: model_cfg.vbp    = w[DIM_W-1:0];
						default: ;
					endcase
				end
				CMD_VSET: begin
					if (i == 0) begin
						model_cfg.vset = w[DIM_W-1:0];
					end
				end
				CMD_HSET: begin
					if (i == 0) begin
						model_cfg.freescale = w[WORD_W-1];
						model_cfg.hset      = w[DIM_W-1:0];
					end
				end
				CMD_ASPECT: begin
					if (i == 0) begin
						model_cfg.arx = w[ASPECT_W-1:0];
					end else if (i == 1) begin
						model_cfg.ary = w[ASPECT_W-1:0];
					end
				end
				default: ;
			endcase
		end
	endtask

	task automatic check_window(input int t_hmin, input int t_hmax, input int t_vmin,
		input int t_vmax, input int t_htot, input int t_vtot);
		int wid;
		int hgt;
		int eff_w;
		int eff_h;
		int ax;
		int ay;
		int tgt_w;
		int tgt_h;
		int hmin;
		int vmin;
		int cycles;
		wid   = model_cfg.width;
		hgt   = model_cfg.height;
		ax    = model_cfg.arx;
		ay    = model_cfg.ary;
		eff_w = (model_cfg.hset != 0 && model_cfg.hset < wid) ? model_cfg.hset : wid;
		eff_h = (model_cfg.vset != 0 && model_cfg.vset < hgt) ? model_cfg.vset : hgt;
		if (model_cfg.freescale || ax == 0 || ay == 0) begin
			tgt_w = eff_w;
			tgt_h = eff_h;
		end else if (ax >= 4096 || ay >= 4096) begin
			// Top aspect bit marks an absolute picture size
			tgt_w = ax % 4096;
			tgt_h = ay % 4096;
		end else begin
			tgt_w = (eff_h * ax / ay > 4095) ? 4095 : eff_h * ax / ay;
			tgt_h = (eff_w * ay / ax > 4095) ? 4095 : eff_w * ay / ax;
		end
		tgt_w = (tgt_w > eff_w) ? eff_w : tgt_w;
		tgt_h = (tgt_h > eff_h) ? eff_h : tgt_h;
		hmin  = (wid - tgt_w) / 2;
		vmin  = (hgt - tgt_h) / 2;
		check_value("trace hmin vs model", t_hmin, hmin);
		check_value("trace hmax vs model", t_hmax, (hmin + tgt_w - 1) & 'hFFF);
		check_value("trace vmin vs model", t_vmin, vmin);
		check_value("trace vmax vs model", t_vmax, (vmin + tgt_h - 1) & 'hFFF);
		check_value("trace htotal vs model", t_htot,
			(wid + model_cfg.hfp + model_cfg.hs + model_cfg.hbp) & 'hFFF);
		check_value("trace vtotal vs model", t_vtot,
			(hgt + model_cfg.vfp + model_cfg.vs + model_cfg.vbp) & 'hFFF);
		cycles = 0;
		while (!window.valid) begin
			@(negedge clk_sys);
			cycles++;
			if (cycles > WAIT_LIMIT) begin
				stop_run("The window never became valid");
			end
		end
		check_value("hmin", window.hmin, t_hmin);
		check_value("hmax", window.hmax, t_hmax);
		check_value("vmin", window.vmin, t_vmin);
		check_value("vmax", window.vmax, t_vmax);
		check_value("htotal", window.htotal, t_htot);
		check_value("vtotal", window.vtotal, t_vtot);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Trace replay
	////////////////////////////////////////////////////////////////////////////

	initial begin
		int                fd;
		int                code;
		int                count;
		int                e0;
		int                e1;
		int                e2;
		int                e3;
		int                e4;
		int                e5;
		logic [7:0]        kind;
		logic [7:0]        cmd;
		logic [WORD_W-1:0] word;
		logic [8*256-1:0]  line;
		video_cfg_t        cfg_before;
		clk_sys     = 1'b0;
		resetd      = 1'b1;
		host_data   = '0;
		host_frame  = 1'b0;
		host_strobe = 1'b0;
		saw_invalid = 1'b0;
		check_count = 0;
		seed_val    = $urandom(32'ha320);
		model_cfg   = '{width: DEF_WIDTH, hfp: DEF_HFP, hs: DEF_HS, hbp: DEF_HBP,
			height: DEF_HEIGHT, vfp: DEF_VFP, vs: DEF_VS, vbp: DEF_VBP,
			hset: '0, vset: '0, freescale: 1'b0, arx: '0, ary: '0};
		repeat (2) @(negedge clk_sys);
		resetd = 1'b0;
		fd = $fopen("video_window_trace.txt", "r");
		if (fd == 0) begin
			stop_run("Cannot open the trace file video_window_trace.txt");
		end
		while (!$feof(fd)) begin
			code = $fscanf(fd, " %c", kind);
			if (code != 1) begin
				break;
			end
			if (kind == "#") begin
				code = $fgets(line, fd);
			end else if (kind == "F" || kind == "X") begin
				code = $fscanf(fd, "%h %d", cmd, count);
				frame_words.delete();
				for (int i = 0; i < count; i++) begin
					code = $fscanf(fd, "%h", word);
					frame_words.push_back(word);
				end
				cfg_before = model_cfg;
				send_frame(cmd, kind == "X");
				apply_frame(cmd, (kind == "X") ? count - 1 : count);
				if (model_cfg != cfg_before) begin
					check_value("valid low after update", saw_invalid, 1);
				end
			end else if (kind == "E") begin
				code = $fscanf(fd, "%d %d %d %d %d %d", e0, e1, e2, e3, e4, e5);
				check_window(e0, e1, e2, e3, e4, e5);
			end else begin
				stop_run($sformatf("Trace line of unknown kind '%c'", kind));
			end
		end
		$fclose(fd);
		if (check_count > 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

endmodule

// File: umuldiv.sv
/*
 * Sequential multiply-divide
 * Computes mul1 * mul2 / div with a single-cycle product and a
 * restoring divider, saturating on overflow or a zero divisor
 */
module umuldiv #(
	parameter int DIM_W = vid_window_pkg::DIM_W
) (
	input  logic             i_clk_sys,
	input  logic             i_resetd,
	input  logic             i_start,
	input  logic [DIM_W-1:0] i_mul1,
	input  logic [DIM_W-1:0] i_mul2,
	input  logic [DIM_W-1:0] i_div,
	output logic             o_busy,
	output logic [DIM_W-1:0] o_result
);

	logic [DIM_W-1:0]             rem;
	logic [DIM_W-1:0]             quo;
	logic [DIM_W-1:0]             div_q;
	logic [DIM_W:0]               trial;
	logic [$clog2(DIM_W+1)-1:0]   step_cnt;
	logic                         sat;

	// Partial remainder with the next dividend bit shifted in
	assign trial    = {rem, quo[DIM_W-1]};
	assign o_result = sat ? '1 : quo;

	always_ff @(posedge i_clk_sys) begin
		if (i_resetd) begin
			o_busy   <= 1'b0;
			step_cnt <= '0;
		end else if (i_start) begin
			o_busy   <= 1'b1;
			step_cnt <= '0;
		end else if (o_busy) begin
			step_cnt <= step_cnt + 1'b1;
			if (32'(step_cnt) == DIM_W) begin
				o_busy <= 1'b0;
			end
		end
	end

	// Upper product half becomes the starting remainder
	always_ff @(posedge i_clk_sys) begin
		if (i_start) begin
			{rem, quo} <= i_mul1 * i_mul2;
			div_q      <= i_div;
		end else if (o_busy) begin
			if (step_cnt == '0) begin
				// Quotient too wide when the high half already reaches div
				sat <= (div_q == '0) || (rem >= div_q);
			end else if (trial >= {1'b0, div_q}) begin
				rem <= DIM_W'(trial - {1'b0, div_q});
				quo <= {quo[DIM_W-2:0], 1'b1};
			end else begin
				rem <= trial[DIM_W-1:0];
				quo <= {quo[DIM_W-2:0], 1'b0};
			end
		end
	end

endmodule

// File: vid_window_pkg.sv
/*
 * Video window package
 * Widths, reset timing defaults, command and state encodings and the
 * structs passed between the host receiver, the command decoder and
 * the window calculator
 */
package vid_window_pkg;

	// Data path widths
	localparam int DIM_W    = 12;
	localparam int ASPECT_W = 13;
	localparam int WORD_W   = 16;

	// CEA 1920x1080 at 60 Hz timing
	localparam logic [DIM_W-1:0] DEF_WIDTH  = 12'd1920;
	localparam logic [DIM_W-1:0] DEF_HFP    = 12'd88;
	localparam logic [DIM_W-1:0] DEF_HS     = 12'd44;
	localparam logic [DIM_W-1:0] DEF_HBP    = 12'd148;
	localparam logic [DIM_W-1:0] DEF_HEIGHT = 12'd1080;
	localparam logic [DIM_W-1:0] DEF_VFP    = 12'd4;
	localparam logic [DIM_W-1:0] DEF_VS     = 12'd5;
	localparam logic [DIM_W-1:0] DEF_VBP    = 12'd36;

	// Command byte at the head of each host frame
	typedef enum logic [7:0] {
		CMD_NONE   = 8'h00,
		CMD_TIMING = 8'h20,
		CMD_VSET   = 8'h27,
		CMD_HSET   = 8'h37,
		CMD_ASPECT = 8'h3A
	} cmd_e;

	// Window calculator sequence
	typedef enum logic [2:0] {
		SNAPSHOT,
		MUL_W,
		WAIT_W,
		MUL_H,
		WAIT_H,
		CLAMP,
		CENTRE,
		PUBLISH
	} calc_state_e;

	// One captured host word
	typedef struct packed {
		logic              valid;
		logic              first;
		logic [WORD_W-1:0] data;
	} host_word_t;

	// Configuration registers seen by the calculator
	typedef struct packed {
		logic [DIM_W-1:0]    width;
		logic [DIM_W-1:0]    hfp;
		logic [DIM_W-1:0]    hs;
		logic [DIM_W-1:0]    hbp;
		logic [DIM_W-1:0]    height;
		logic [DIM_W-1:0]    vfp;
		logic [DIM_W-1:0]    vs;
		logic [DIM_W-1:0]    vbp;
		logic [DIM_W-1:0]    hset;
		logic [DIM_W-1:0]    vset;
		logic                freescale;
		logic [ASPECT_W-1:0] arx;
		logic [ASPECT_W-1:0] ary;
	} video_cfg_t;

	// Published picture window and totals
	typedef struct packed {
		logic             valid;
		logic [DIM_W-1:0] hmin;
		logic [DIM_W-1:0] hmax;
		logic [DIM_W-1:0] vmin;
		logic [DIM_W-1:0] vmax;
		logic [DIM_W-1:0] htotal;
		logic [DIM_W-1:0] vtotal;
	} window_t;

endpackage

// File: video_cmd_decoder.sv
/*
 * Video command decoder
 * Parses host frames into the timing, override and aspect registers
 * and flags every change to the window calculator
 */
module video_cmd_decoder (
	input  logic                        i_clk_sys,
	input  logic                        i_resetd,
	input  vid_window_pkg::host_word_t  i_word,
	input  logic                        i_host_frame_sync,
	output vid_window_pkg::video_cfg_t  o_cfg,
	output logic                        o_cfg_update
);
	import vid_window_pkg::*;

	cmd_e       cmd_q;
	logic [3:0] word_cnt;
	logic       data_word;
	video_cfg_t cfg_next;

	// Unknown command bytes park the parser
	function automatic cmd_e decode_cmd(input logic [7:0] cmd_byte);
		cmd_e cmd;
		case (cmd_byte)
			CMD_TIMING: cmd = CMD_TIMING;
			CMD_VSET:   cmd = CMD_VSET;
			CMD_HSET:   cmd = CMD_HSET;
			CMD_ASPECT: cmd = CMD_ASPECT;
			default:    cmd = CMD_NONE;
		endcase
		return cmd;
	endfunction

	assign data_word = i_word.valid & ~i_word.first & i_host_frame_sync;

	////////////////////////////////////////////////////////////////////////////
	// Register write decode
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		cfg_next = o_cfg;
		if (data_word) begin
			case (cmd_q)
				CMD_TIMING: begin
					// Words past the eighth fall through
					case (word_cnt)
						4'd0: cfg_next.width  = i_word.data[DIM_W-1:0];
						4'd1: cfg_next.hfp    = i_word.data[DIM_W-1:0];
						4'd2: cfg_next.hs     = i_word.data[DIM_W-1:0];
						4'd3: cfg_next.hbp    = i_word.data[DIM_W-1:0];
						4'd4: cfg_next.height = i_word.data[DIM_W-1:0];
						4'd5: cfg_next.vfp    = i_word.data[DIM_W-1:0];
						4'd6: cfg_next.vs     = i_word.data[DIM_W-1:0];
						4'd7: cfg_next.vbp    = i_word.data[DIM_W-1:0];
						default: ;
					endcase
				end
				CMD_VSET: begin
					if (word_cnt == 4'd0) begin
						cfg_next.vset = i_word.data[DIM_W-1:0];
					end
				end
				CMD_HSET: begin
					if (word_cnt == 4'd0) begin
						cfg_next.freescale = i_word.data[WORD_W-1];
						cfg_next.hset      = i_word.data[DIM_W-1:0];
					end
				end
				CMD_ASPECT: begin
					if (word_cnt == 4'd0) begin
						cfg_next.arx = i_word.data[ASPECT_W-1:0];
					end else if (word_cnt == 4'd1) begin
						cfg_next.ary = i_word.data[ASPECT_W-1:0];
					end
				end
				default: ;
			endcase
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Parser state and configuration registers
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge i_clk_sys) begin
		if (i_resetd) begin
			cmd_q        <= CMD_NONE;
			word_cnt     <= '0;
			o_cfg_update <= 1'b0;
			o_cfg        <= '{
				width:     DEF_WIDTH,
				hfp:       DEF_HFP,
				hs:        DEF_HS,
				hbp:       DEF_HBP,
				height:    DEF_HEIGHT,
				vfp:       DEF_VFP,
				vs:        DEF_VS,
				vbp:       DEF_VBP,
				hset:      '0,
				vset:      '0,
				freescale: 1'b0,
				arx:       '0,
				ary:       '0
			};
		end else begin
			o_cfg        <= cfg_next;
			o_cfg_update <= (cfg_next != o_cfg);
			if (!i_host_frame_sync) begin
				cmd_q    <= CMD_NONE;
				word_cnt <= '0;
			end else if (i_word.valid) begin
				if (i_word.first) begin
					cmd_q    <= decode_cmd(i_word.data[7:0]);
					word_cnt <= '0;
				end else if (word_cnt != 4'd8) begin
					// Saturate once the longest command is complete
					word_cnt <= word_cnt + 4'd1;
				end
			end
		end
	end

endmodule

// File: video_window.f
vid_window_pkg.sv
host_word_rx.sv
video_cmd_decoder.sv
umuldiv.sv
window_calc.sv
video_window_top.sv
tb_video_window.sv

// File: video_window_top.sv
/*
 * Video window block
 * Host link receiver, command decoder and window calculator
 */
module video_window_top (
	input  logic                              i_clk_sys,
	input  logic                              i_resetd,
	input  logic [vid_window_pkg::WORD_W-1:0] i_host_data,
	input  logic                              i_host_frame,
	input  logic                              i_host_strobe,
	output logic                              o_host_ack,
	output vid_window_pkg::window_t           o_window
);
	import vid_window_pkg::*;

	host_word_t host_word;
	logic       frame_sync;
	video_cfg_t cfg;
	logic       cfg_update;

	host_word_rx host_rx_i (
		.i_clk_sys     (i_clk_sys),
		.i_resetd      (i_resetd),
		.i_host_data   (i_host_data),
		.i_host_frame  (i_host_frame),
		.i_host_strobe (i_host_strobe),
		.o_word        (host_word),
		.o_frame_sync  (frame_sync),
		.o_host_ack    (o_host_ack)
	);

	video_cmd_decoder cmd_dec_i (
		.i_clk_sys         (i_clk_sys),
		.i_resetd          (i_resetd),
		.i_word            (host_word),
		.i_host_frame_sync (frame_sync),
		.o_cfg             (cfg),
		.o_cfg_update      (cfg_update)
	);

	window_calc win_calc_i (
		.i_clk_sys    (i_clk_sys),
		.i_resetd     (i_resetd),
		.i_cfg        (cfg),
		.i_cfg_update (cfg_update),
		.o_window     (o_window)
	);

endmodule

// File: video_window_trace.txt
# F <cmd> <n> <word>...   frame; command and words in hex, word count n in decimal
# X <cmd> <n> <word>...   same, frame dropped while its last word is sent
# E <hmin> <hmax> <vmin> <vmax> <htotal> <vtotal>   expected window, decimal
# Defaults after reset
E 0 1919 0 1079 2200 1125
# 720p timing
F 20 8 0500 006E 0028 00DC 02D0 0005 0005 0014
E 0 1279 0 719 1650 750
# Back to 1080p, then 4:3 pillarbox
F 20 8 0780 0058 002C 0094 0438 0004 0005 0024
E 0 1919 0 1079 2200 1125
F 3A 2 0004 0003
E 240 1679 0 1079 2200 1125
# Free scale restores full width
F 37 1 8000
E 0 1919 0 1079 2200 1125
# User overrides below the timing
F 37 1 0500
E 320 1599 60 1019 2200 1125
F 27 1 02D0
E 480 1439 180 899 2200 1125
# Overrides at or above the timing are ignored
F 37 1 07D0
F 27 1 0438
E 240 1679 0 1079 2200 1125
# Absolute size 800x600
F 3A 2 1320 1258
E 560 1359 240 839 2200 1125
# Aborted timing frame, last word lost
X 20 4 0780 0058 002C 03E7
E 560 1359 240 839 2200 1125
F 27 1 01F4
E 560 1359 290 789 2200 1125
# Unknown command
F 55 2 0123 0456
E 560 1359 290 789 2200 1125
# Absolute size clamped to the effective area
F 3A 2 17D0 11F4
E 0 1919 290 789 2200 1125
# Back-to-back frames
F 27 1 0000
F 37 1 0000
F 20 8 0500 006E 0028 00DC 02D0 0005 0005 0014
F 3A 2 0004 0003
E 160 1119 0 719 1650 750
# Ratio product saturates
F 3A 2 0FFF 0100
E 0 1279 320 399 1650 750

// File: window_calc.sv
/*
 * Window calculator
 * Derives the centred picture window from timing, user override and
 * aspect ratio, and publishes it with the horizontal and vertical totals
 */
module window_calc (
	input  logic                        i_clk_sys,
	input  logic                        i_resetd,
	input  vid_window_pkg::video_cfg_t  i_cfg,
	input  logic                        i_cfg_update,
	output vid_window_pkg::window_t     o_window
);
	import vid_window_pkg::*;

	calc_state_e      state;
	logic             pending;
	logic [DIM_W-1:0] width_s;
	logic [DIM_W-1:0] height_s;
	logic [DIM_W-1:0] eff_w;
	logic [DIM_W-1:0] eff_h;
	logic [DIM_W-1:0] arx_s;
	logic [DIM_W-1:0] ary_s;
	logic [DIM_W-1:0] htotal_s;
	logic [DIM_W-1:0] vtotal_s;
	logic [DIM_W-1:0] tgt_w;
	logic [DIM_W-1:0] tgt_h;
	logic [DIM_W-1:0] hmin_c;
	logic [DIM_W-1:0] vmin_c;
	logic [DIM_W-1:0] cfg_eff_w;
	logic [DIM_W-1:0] cfg_eff_h;
	logic             aspect_free;
	logic             aspect_abs;
	logic             md_start;
	logic             md_busy;
	logic [DIM_W-1:0] md_mul1;
	logic [DIM_W-1:0] md_mul2;
	logic [DIM_W-1:0] md_div;
	logic [DIM_W-1:0] md_result;

	// Override only when nonzero and smaller than the active area
	assign cfg_eff_w = (i_cfg.hset != '0 && i_cfg.hset < i_cfg.width) ? i_cfg.hset : i_cfg.width;
	assign cfg_eff_h = (i_cfg.vset != '0 && i_cfg.vset < i_cfg.height) ? i_cfg.vset :
		i_cfg.height;

	assign aspect_free = i_cfg.freescale | (i_cfg.arx == '0) | (i_cfg.ary == '0);
	assign aspect_abs  = i_cfg.arx[ASPECT_W-1] | i_cfg.ary[ASPECT_W-1];

	umuldiv #(
		.DIM_W (DIM_W)
	) muldiv_i (
		.i_clk_sys (i_clk_sys),
		.i_resetd  (i_resetd),
		.i_start   (md_start),
		.i_mul1    (md_mul1),
		.i_mul2    (md_mul2),
		.i_div     (md_div),
		.o_busy    (md_busy),
		.o_result  (md_result)
	);

	always_ff @(posedge i_clk_sys) begin
		if (i_resetd) begin
			state          <= SNAPSHOT;
			pending        <= 1'b1;
			md_start       <= 1'b0;
			o_window.valid <= 1'b0;
		end else begin
			md_start <= 1'b0;
			case (state)
				SNAPSHOT: begin
					if (pending) begin
						pending  <= 1'b0;
						width_s  <= i_cfg.width;
						height_s <= i_cfg.height;
						eff_w    <= cfg_eff_w;
						eff_h    <= cfg_eff_h;
						arx_s    <= i_cfg.arx[DIM_W-1:0];
						ary_s    <= i_cfg.ary[DIM_W-1:0];
						htotal_s <= i_cfg.width + i_cfg.hfp + i_cfg.hs + i_cfg.hbp;
						vtotal_s <= i_cfg.height + i_cfg.vfp + i_cfg.vs + i_cfg.vbp;
						if (aspect_free) begin
							tgt_w <= cfg_eff_w;
							tgt_h <= cfg_eff_h;
							state <= CLAMP;
						end else if (aspect_abs) begin
							// Absolute picture size
							tgt_w <= i_cfg.arx[DIM_W-1:0];
							tgt_h <= i_cfg.ary[DIM_W-1:0];
							state <= CLAMP;
						end else begin
							state <= MUL_W;
						end
					end
				end
				MUL_W: begin
					md_mul1  <= eff_h;
					md_mul2  <= arx_s;
					md_div   <= ary_s;
					md_start <= 1'b1;
					state    <= WAIT_W;
				end
				WAIT_W: begin
					if (!md_start && !md_busy) begin
						tgt_w <= md_result;
						state <= MUL_H;
					end
				end
				MUL_H: begin
					md_mul1  <= eff_w;
					md_mul2  <= ary_s;
					md_div   <= arx_s;
					md_start <= 1'b1;
					state    <= WAIT_H;
				end
				WAIT_H: begin
					if (!md_start && !md_busy) begin
						tgt_h <= md_result;
						state <= CLAMP;
					end
				end
				CLAMP: begin
					if (tgt_w > eff_w) begin
						tgt_w <= eff_w;
					end
					if (tgt_h > eff_h) begin
						tgt_h <= eff_h;
					end
					state <= CENTRE;
				end
				CENTRE: begin
					hmin_c <= (width_s - tgt_w) >> 1;
					vmin_c <= (height_s - tgt_h) >> 1;
					state  <= PUBLISH;
				end
				PUBLISH: begin
					// Stale pass is dropped and the loop restarts
					if (!pending) begin
						o_window <= '{
							valid:  1'b1,
							hmin:   hmin_c,
							hmax:   hmin_c + tgt_w - 1'b1,
							vmin:   vmin_c,
							vmax:   vmin_c + tgt_h - 1'b1,
							htotal: htotal_s,
							vtotal: vtotal_s
						};
					end
					state <= SNAPSHOT;
				end
				default: state <= SNAPSHOT;
			endcase
			// Any change invalidates the window and queues a new pass
			if (i_cfg_update) begin
				pending        <= 1'b1;
				o_window.valid <= 1'b0;
			end
		end
	end

endmodule
